/* hdl/ucodePkg.sv */
package ucodePkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	// Opcode byte from the fetch stream
	typedef logic [7:0] opcodeT;

	// 64 entry microcode ROM
	typedef logic [5:0] uAddrT;

	// Packed as {nextAction, uopCode, operand}
	typedef logic [14:0] uopT;

	//////////////////////////////////////////////////////////////////////
	// Micro-op fields
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0]
	{
		actOp          = 4'd0,
		actInc         = 4'd1,
		actEof         = 4'd2,
		actIncEof      = 4'd3,
		actIncEofZ     = 4'd4,
		actIncEofNz    = 4'd5,
		actEofFu       = 4'd6,
		actIncEofFu    = 4'd7,
		actUpdateFlags = 4'd8
	} nextActionT;

	typedef enum logic [4:0]
	{
		uNop, uSma, uSmw, uSrm, uSx16r, uSrx16, uAddx16,
		uSubx16, uSpc, uDec16, uInc16, uBit, uShl, uZ801bop
	} uopCodeT;

	typedef enum logic [5:0]
	{
		oNull, oA, oB, oC, oH, oL, oPc, oSp, oHl, oX8, oX16, oPch
	} operandT;

	//////////////////////////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////////////////////////

	localparam opcodeT opNop      = 8'h00;
	localparam opcodeT opLdBn     = 8'h06;
	localparam opcodeT opLdCn     = 8'h0E;
	localparam opcodeT opAddAB    = 8'h80;
	localparam opcodeT opSubB     = 8'h90;
	localparam opcodeT opJrNz     = 8'h20;
	localparam opcodeT opJrZ      = 8'h28;
	localparam opcodeT opPushBc   = 8'hC5;
	localparam opcodeT opPrefixCb = 8'hCB;
	// Second byte after the prefix
	localparam opcodeT cbBit7H    = 8'h7C;
	localparam opcodeT cbRlC      = 8'h11;

	//////////////////////////////////////////////////////////////////////
	// Flow start addresses laid out contiguously from 0
	//////////////////////////////////////////////////////////////////////

	localparam uAddrT flowGeneric  = 6'd0;
	localparam uAddrT flowNop      = 6'd2;
	localparam uAddrT flowLdBn     = 6'd3;
	localparam uAddrT flowLdCn     = 6'd6;
	localparam uAddrT flowAddB     = 6'd9;
	localparam uAddrT flowSubB     = 6'd12;
	localparam uAddrT flowJrNz     = 6'd15;
	localparam uAddrT flowJrZ      = 6'd21;
	localparam uAddrT flowPushBc   = 6'd27;
	localparam uAddrT flowPrefixCb = 6'd33;
	localparam uAddrT flowBit7     = 6'd36;
	// Last ROM entry in use
	localparam uAddrT flowRlC      = 6'd37;

	typedef enum logic {seqIdle, seqRun} seqStateT;

endpackage

/* hdl/opcodeDecoder.sv */
`timescale 1ns/1ps

module opcodeDecoder
(
	input  logic             clk,
	input  logic             rst,
	input  logic             opValid,
	input  ucodePkg::opcodeT opcode,
	output logic             opReady,
	output logic             flowValid,
	output ucodePkg::uAddrT  flowStart,
	input  logic             flowReady
);
	import ucodePkg::*;

	uAddrT mainStart;
	uAddrT cbStart;
	logic  prefixPending;
	logic  opAccept;

	//////////////////////////////////////////////////////////////////////
	// Lookup tables
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (opcode)
			opNop:      mainStart = flowNop;
			opLdBn:     mainStart = flowLdBn;
			opLdCn:     mainStart = flowLdCn;
			opAddAB:    mainStart = flowAddB;
			opSubB:     mainStart = flowSubB;
			opJrNz:     mainStart = flowJrNz;
			opJrZ:      mainStart = flowJrZ;
			opPushBc:   mainStart = flowPushBc;
			opPrefixCb: mainStart = flowPrefixCb;
			default:    mainStart = flowGeneric;
		endcase
	end

	// Unknown CB bytes fall back to the one-byte flow
	always_comb
	begin
		case (opcode)
			cbBit7H: cbStart = flowBit7;
			cbRlC:   cbStart = flowRlC;
			default: cbStart = flowGeneric;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// One-entry output register
	//////////////////////////////////////////////////////////////////////

	assign opReady  = !flowValid || flowReady;
	assign opAccept = opValid && opReady;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			flowValid     <= 1'b0;
			prefixPending <= 1'b0;
		end
		else if (opAccept)
		begin
			flowValid     <= 1'b1;
			// A CB while pending is itself a prefix-table byte
			prefixPending <= !prefixPending && (opcode == opPrefixCb);
		end
		else if (flowReady)
		begin
			flowValid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (opAccept)
		begin
			flowStart <= prefixPending ? cbStart : mainStart;
		end
	end

	// Waiting flow survives until the sequencer takes it
	assert property (@(posedge clk) disable iff (rst)
		(flowValid && !flowReady) |=> (flowValid && $stable(flowStart)));

endmodule

/* hdl/microcodeRom.sv */
`timescale 1ns/1ps

module microcodeRom
(
	input  ucodePkg::uAddrT uAddr,
	output ucodePkg::uopT   uop
);
	import ucodePkg::*;

	always_comb
	begin
		case (uAddr)
			//////////////////////////////////////////////////////////////////
			// Generic one-byte op
			//////////////////////////////////////////////////////////////////
			flowGeneric:         uop = {actUpdateFlags, uZ801bop, oA};
			flowGeneric + 6'd1:  uop = {actIncEof, uNop, oNull};

			// NOP
			flowNop:             uop = {actIncEof, uNop, oNull};

			//////////////////////////////////////////////////////////////////
			// Immediate loads
			//////////////////////////////////////////////////////////////////
			// Address the immediate byte
			flowLdBn:            uop = {actInc, uSma, oPc};
			flowLdBn + 6'd1:     uop = {actInc, uNop, oNull};
			flowLdBn + 6'd2:     uop = {actEof, uSrm, oB};

			flowLdCn:            uop = {actInc, uSma, oPc};
			flowLdCn + 6'd1:     uop = {actInc, uNop, oNull};
			flowLdCn + 6'd2:     uop = {actEof, uSrm, oC};

			//////////////////////////////////////////////////////////////////
			// 8-bit ALU through x16
			//////////////////////////////////////////////////////////////////
			flowAddB:            uop = {actOp, uSx16r, oA};
			flowAddB + 6'd1:     uop = {actUpdateFlags, uAddx16, oB};
			flowAddB + 6'd2:     uop = {actIncEof, uSrx16, oA};

			flowSubB:            uop = {actOp, uSx16r, oA};
			flowSubB + 6'd1:     uop = {actUpdateFlags, uSubx16, oB};
			flowSubB + 6'd2:     uop = {actIncEof, uSrx16, oA};

			//////////////////////////////////////////////////////////////////
			// Relative jumps
			//////////////////////////////////////////////////////////////////
			flowJrNz:            uop = {actInc, uSma, oPc};
			flowJrNz + 6'd1:     uop = {actOp, uNop, oNull};
			// Not taken when Z is set, else latch the offset
			flowJrNz + 6'd2:     uop = {actIncEofZ, uSrm, oX8};
			flowJrNz + 6'd3:     uop = {actOp, uSx16r, oPc};
			// Sign-extended offset added to PC
			flowJrNz + 6'd4:     uop = {actOp, uAddx16, oX8};
			flowJrNz + 6'd5:     uop = {actEof, uSpc, oX16};

			flowJrZ:             uop = {actInc, uSma, oPc};
			flowJrZ + 6'd1:      uop = {actOp, uNop, oNull};
			flowJrZ + 6'd2:      uop = {actIncEofNz, uSrm, oX8};
			flowJrZ + 6'd3:      uop = {actOp, uSx16r, oPc};
			flowJrZ + 6'd4:      uop = {actOp, uAddx16, oX8};
			flowJrZ + 6'd5:      uop = {actEof, uSpc, oX16};

			//////////////////////////////////////////////////////////////////
			// PUSH BC
			//////////////////////////////////////////////////////////////////
			flowPushBc:          uop = {actOp, uDec16, oSp};
			flowPushBc + 6'd1:   uop = {actOp, uSma, oSp};
			flowPushBc + 6'd2:   uop = {actOp, uSmw, oB};
			flowPushBc + 6'd3:   uop = {actOp, uDec16, oSp};
			flowPushBc + 6'd4:   uop = {actOp, uSmw, oC};
			// Point memory back at the fetch address
			flowPushBc + 6'd5:   uop = {actIncEof, uSma, oPc};

			//////////////////////////////////////////////////////////////////
			// CB prefix and its second bytes
			//////////////////////////////////////////////////////////////////
			// Fetch of the second byte, decoded upstream
			flowPrefixCb:        uop = {actInc, uSma, oPc};
			flowPrefixCb + 6'd1: uop = {actOp, uNop, oNull};
			flowPrefixCb + 6'd2: uop = {actIncEof, uNop, oNull};

			flowBit7:            uop = {actEofFu, uBit, oH};
			flowRlC:             uop = {actEofFu, uShl, oC};

			default:             uop = {actOp, uNop, oNull};
		endcase
	end

endmodule

/* hdl/microSequencer.sv */
`timescale 1ns/1ps

module microSequencer
(
	input  logic            clk,
	input  logic            rst,
	input  logic            flowValid,
	input  ucodePkg::uAddrT flowStart,
	output logic            flowReady,
	input  logic            zeroFlag,
	output logic            uopValid,
	output ucodePkg::uopT   uop,
	input  logic            uopReady
);
	import ucodePkg::*;

	seqStateT   state;
	uAddrT      uPc;
	uAddrT      romAddr;
	uopT        romUop;
	nextActionT action;
	logic       uopXfer;
	logic       flowEnds;
	logic       endXfer;
	logic       loadFlow;

	microcodeRom rom
	(
		.uAddr(romAddr),
		.uop  (romUop)
	);

	//////////////////////////////////////////////////////////////////////
	// End-of-flow decision
	//////////////////////////////////////////////////////////////////////

	assign action  = nextActionT'(uop[14:11]);
	assign uopXfer = uopValid && uopReady;

	always_comb
	begin
		case (action)
			actEof, actIncEof, actEofFu, actIncEofFu: flowEnds = 1'b1;
			actIncEofZ:  flowEnds = zeroFlag;
			actIncEofNz: flowEnds = !zeroFlag;
			default:     flowEnds = 1'b0;
		endcase
	end

	assign endXfer = uopXfer && flowEnds;

	// Queued flow can start right behind the ending micro-op
	assign flowReady = (state == seqIdle) || endXfer;
	assign loadFlow  = flowValid && flowReady;
	assign romAddr   = loadFlow ? flowStart : uPc + 6'd1;
	assign uopValid  = (state == seqRun);

	//////////////////////////////////////////////////////////////////////
	// FSM and micro-PC
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= seqIdle;
		end
		else if (loadFlow)
		begin
			state <= seqRun;
		end
		else if (endXfer)
		begin
			state <= seqIdle;
		end
	end

	always_ff @(posedge clk)
	begin
		if (loadFlow || (uopXfer && !flowEnds))
		begin
			uPc <= romAddr;
			uop <= romUop;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		(uopValid && !uopReady) |=> (uopValid && $stable(uop)));

	// Every flow in the ROM ends before running off the table
	assert property (@(posedge clk) disable iff (rst)
		(state == seqRun) |-> (uPc <= flowRlC));

endmodule

/* hdl/ucodeFrontEnd.sv */
`timescale 1ns/1ps

module ucodeFrontEnd
(
	input  logic             clk,
	input  logic             rst,
	input  logic             opValid,
	input  ucodePkg::opcodeT opcode,
	output logic             opReady,
	input  logic             zeroFlag,
	output logic             uopValid,
	output ucodePkg::uopT    uop,
	input  logic             uopReady
);
	import ucodePkg::*;

	// Decoded flow between the two stages
	logic  flowValid;
	uAddrT flowStart;
	logic  flowReady;

	opcodeDecoder decoder
	(
		.clk      (clk),
		.rst      (rst),
		.opValid  (opValid),
		.opcode   (opcode),
		.opReady  (opReady),
		.flowValid(flowValid),
		.flowStart(flowStart),
		.flowReady(flowReady)
	);

	microSequencer sequencer
	(
		.clk      (clk),
		.rst      (rst),
		.flowValid(flowValid),
		.flowStart(flowStart),
		.flowReady(flowReady),
		.zeroFlag (zeroFlag),
		.uopValid (uopValid),
		.uop      (uop),
		.uopReady (uopReady)
	);

endmodule

/* testbench/clockGen.sv */
`timescale 1ns/1ps

module clockGen
#(
	parameter int period      = 40,
	parameter int resetCycles = 3
)
(
	output logic clk,
	output logic rst
);
	initial
	begin
		clk = 1'b0;
		forever #(period / 2) clk = !clk;
	end

	// Release lands just after a rising edge
	initial
	begin
		rst = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#1;
		rst = 1'b0;
	end

endmodule

/* testbench/ucodeFrontEndTb.sv */
`timescale 1ns/1ps

module ucodeFrontEndTb;
	import ucodePkg::*;

	localparam int clkPeriod     = 40;
	localparam int numTests      = 6;
	// Watchdog budget per directed test
	localparam int cyclesPerTest = 200;

	logic   clk;
	logic   rst;
	logic   opValid;
	opcodeT opcode;
	logic   opReady;
	logic   zeroFlag;
	logic   uopValid;
	uopT    uop;
	logic   uopReady;

	// Expected micro-ops with the oldest first
	uopT    expQ[$];
	logic   readyPattern[256];
	int     patIdx;
	logic   randomReady;
	logic   nextReady;
	logic   cbPending;
	int     errorCount;
	int     seedVal;
	logic   prevHeld;
	uopT    prevUop;
	int     heldCount;
	int     stallCount;
	logic   gapCheck;
	logic   flowStarted;
	int     gapCount;

	clockGen #(.period(clkPeriod), .resetCycles(3)) clocks (.clk(clk), .rst(rst));

	ucodeFrontEnd uut
	(
		.clk     (clk),
		.rst     (rst),
		.opValid (opValid),
		.opcode  (opcode),
		.opReady (opReady),
		.zeroFlag(zeroFlag),
		.uopValid(uopValid),
		.uop     (uop),
		.uopReady(uopReady)
	);

	//////////////////////////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////////////////////////

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			errorCount++;
			$display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	function automatic uopT makeUop(input nextActionT a, input uopCodeT c, input operandT o);
		return {a, c, o};
	endfunction

	// Outputs sampled mid-cycle, so a valid and ready seen here transfer at the next edge
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (prevHeld)
			begin
				checkValue(uopValid, 1'b1, "uopValid dropped under back-pressure");
				checkValue(uop, prevUop, "uop changed under back-pressure");
			end
			prevHeld = uopValid && !uopReady;
			prevUop  = uop;
			if (prevHeld)
				heldCount++;
			if (opValid && !opReady)
				stallCount++;
			if (gapCheck && flowStarted && !uopValid && expQ.size() != 0)
				gapCount++;
			if (uopValid && uopReady)
			begin
				flowStarted = 1'b1;
				if (expQ.size() == 0)
				begin
					errorCount++;
					$display("Unexpected micro-op %h issued at %0t ns", uop, $time);
				end
				else
					checkValue(uop, expQ.pop_front(), "micro-op");
			end
		end
	end

	// Consumer readiness is random only during the back-pressure test
	always @(posedge clk)
	begin
		nextReady = randomReady ? readyPattern[patIdx] : 1'b1;
		if (randomReady)
			patIdx = (patIdx + 1) % 256;
		#1;
		uopReady = nextReady;
	end

	initial
	begin
		#(numTests * cyclesPerTest * clkPeriod);
		$display("Run timed out with %0d micro-ops still expected", expQ.size());
		$display("TESTBENCH FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference flows
	//////////////////////////////////////////////////////////////////////

	task automatic expectJump(input nextActionT condAct, input logic endsEarly);
		expQ.push_back(makeUop(actInc, uSma, oPc));
		expQ.push_back(makeUop(actOp, uNop, oNull));
		expQ.push_back(makeUop(condAct, uSrm, oX8));
		if (!endsEarly)
		begin
			expQ.push_back(makeUop(actOp, uSx16r, oPc));
			expQ.push_back(makeUop(actOp, uAddx16, oX8));
			expQ.push_back(makeUop(actEof, uSpc, oX16));
		end
	endtask

	task automatic expectOpcode(input opcodeT op);
		if (cbPending)
		begin
			cbPending = 1'b0;
			case (op)
				cbBit7H: expQ.push_back(makeUop(actEofFu, uBit, oH));
				cbRlC:   expQ.push_back(makeUop(actEofFu, uShl, oC));
				default:
				begin
					expQ.push_back(makeUop(actUpdateFlags, uZ801bop, oA));
					expQ.push_back(makeUop(actIncEof, uNop, oNull));
				end
			endcase
		end
		else
		begin
			case (op)
				opNop: expQ.push_back(makeUop(actIncEof, uNop, oNull));
				opLdBn, opLdCn:
				begin
					expQ.push_back(makeUop(actInc, uSma, oPc));
					expQ.push_back(makeUop(actInc, uNop, oNull));
					expQ.push_back(makeUop(actEof, uSrm, (op == opLdBn) ? oB : oC));
				end
				opAddAB, opSubB:
				begin
					expQ.push_back(makeUop(actOp, uSx16r, oA));
					expQ.push_back(makeUop(actUpdateFlags,
						(op == opAddAB) ? uAddx16 : uSubx16, oB));
					expQ.push_back(makeUop(actIncEof, uSrx16, oA));
				end
				// JR NZ falls through when Z is set, JR Z when it is clear
				opJrNz: expectJump(actIncEofZ, zeroFlag);
				opJrZ:  expectJump(actIncEofNz, !zeroFlag);
				opPushBc:
				begin
					expQ.push_back(makeUop(actOp, uDec16, oSp));
					expQ.push_back(makeUop(actOp, uSma, oSp));
					expQ.push_back(makeUop(actOp, uSmw, oB));
					expQ.push_back(makeUop(actOp, uDec16, oSp));
					expQ.push_back(makeUop(actOp, uSmw, oC));
					expQ.push_back(makeUop(actIncEof, uSma, oPc));
				end
				opPrefixCb:
				begin
					cbPending = 1'b1;
					expQ.push_back(makeUop(actInc, uSma, oPc));
					expQ.push_back(makeUop(actOp, uNop, oNull));
					expQ.push_back(makeUop(actIncEof, uNop, oNull));
				end
				default:
				begin
					expQ.push_back(makeUop(actUpdateFlags, uZ801bop, oA));
					expQ.push_back(makeUop(actIncEof, uNop, oNull));
				end
			endcase
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic sendOpcode(input opcodeT op);
		expectOpcode(op);
		opValid = 1'b1;
		opcode  = op;
		@(negedge clk);
		while (!opReady)
			@(negedge clk);
		@(posedge clk);
		#1;
		opValid = 1'b0;
	endtask

	// Idle once uopValid stays low for four cycles
	task automatic waitIdle();
		int quiet;
		quiet = 0;
		while (quiet < 4)
		begin
			@(negedge clk);
			if (uopValid)
				quiet = 0;
			else
				quiet++;
		end
		checkValue(expQ.size(), 0, "micro-ops missing at end of test");
		expQ.delete();
		@(posedge clk);
		#1;
	endtask

	task automatic sendStraightFlows();
		sendOpcode(opNop);
		sendOpcode(opLdBn);
		sendOpcode(opLdCn);
		sendOpcode(opAddAB);
		sendOpcode(opSubB);
		sendOpcode(opPushBc);
	endtask

	task automatic runJump(input opcodeT op, input logic z);
		zeroFlag = z;
		sendOpcode(op);
		waitIdle();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic checkResetAndLatency();
		@(negedge clk);
		checkValue(uopValid, 1'b0, "uopValid after reset");
		checkValue(opReady, 1'b1, "opReady after reset");
		@(posedge clk);
		#1;
		expectOpcode(opNop);
		opValid = 1'b1;
		opcode  = opNop;
		@(negedge clk);
		checkValue(opReady, 1'b1, "opReady with idle DUT");
		@(posedge clk);
		#1;
		opValid = 1'b0;
		@(negedge clk);
		checkValue(uopValid, 1'b0, "uopValid one cycle after opcode");
		@(negedge clk);
		checkValue(uopValid, 1'b1, "uopValid two cycles after opcode");
		waitIdle();
	endtask

	task automatic runStraightFlows();
		gapCount    = 0;
		flowStarted = 1'b0;
		gapCheck    = 1'b1;
		sendStraightFlows();
		waitIdle();
		gapCheck = 1'b0;
		checkValue(gapCount, 0, "idle cycles between straight-line flows");
	endtask

	task automatic runDefaultDecode();
		sendOpcode(8'h3C);
		sendOpcode(8'hFF);
		waitIdle();
	endtask

	task automatic runConditionalEnd();
		runJump(opJrNz, 1'b1);
		runJump(opJrNz, 1'b0);
		runJump(opJrZ, 1'b1);
		runJump(opJrZ, 1'b0);
		zeroFlag = 1'b0;
	endtask

	task automatic runPrefixDecode();
		sendOpcode(opPrefixCb);
		sendOpcode(cbBit7H);
		sendOpcode(opPrefixCb);
		sendOpcode(cbRlC);
		sendOpcode(opPrefixCb);
		sendOpcode(8'h55);
		sendOpcode(opNop);
		waitIdle();
	endtask

	task automatic runBackPressure();
		heldCount   = 0;
		stallCount  = 0;
		randomReady = 1'b1;
		sendStraightFlows();
		waitIdle();
		randomReady = 1'b0;
		checkValue(heldCount > 0, 1'b1, "cycles with uop held by back-pressure");
		checkValue(stallCount > 0, 1'b1, "cycles with opcode stalled");
	endtask

	initial
	begin
		int i;
		seedVal = 32'h4757;
		void'($urandom(seedVal));
		for (i = 0; i < 256; i++)
			readyPattern[i] = $urandom % 2;
		patIdx      = 0;
		opValid     = 1'b0;
		opcode      = 8'h00;
		zeroFlag    = 1'b0;
		uopReady    = 1'b1;
		randomReady = 1'b0;
		cbPending   = 1'b0;
		errorCount  = 0;
		prevHeld    = 1'b0;
		prevUop     = '0;
		heldCount   = 0;
		stallCount  = 0;
		gapCheck    = 1'b0;
		flowStarted = 1'b0;
		gapCount    = 0;
		@(negedge rst);
		checkResetAndLatency();
		runStraightFlows();
		runDefaultDecode();
		runConditionalEnd();
		runPrefixDecode();
		runBackPressure();
		$display("Directed tests done, %0d errors", errorCount);
		if (errorCount == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* tb.f */
hdl/ucodePkg.sv
hdl/opcodeDecoder.sv
hdl/microcodeRom.sv
hdl/microSequencer.sv
hdl/ucodeFrontEnd.sv
testbench/clockGen.sv
testbench/ucodeFrontEndTb.sv

/* Bender.yml */
package:
  name: ucode_front_end

sources:
  - files:
      - hdl/ucodePkg.sv
      - hdl/opcodeDecoder.sv
      - hdl/microcodeRom.sv
      - hdl/microSequencer.sv
      - hdl/ucodeFrontEnd.sv
  - target: test
    files:
      - testbench/clockGen.sv
      - testbench/ucodeFrontEndTb.sv
